// File: verilog/trace_pkg.sv
// Shared widths, register map and types for the trace trigger; imported by every RTL block
`default_nettype none

package trace_pkg;

   localparam int lane_bits = 4;          // trace data bus width

   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;
   typedef logic [7:0] count_t;           // saturates at 255

   // trigger timing as written through the register bus
   typedef struct packed {
      logic [7:0] delay;                  // cycles before the pulse
      logic [7:0] width;                  // pulse cycles, 0 acts as 1
   } trig_cfg_t;

   // pattern and mask bytes live at base + rule*8 + byte, byte 0 is the LSB
   localparam reg_addr_t addr_pattern_base = 8'h00;
   localparam reg_addr_t addr_mask_base    = 8'h40;
   localparam reg_addr_t addr_count_base   = 8'h80;  // one byte per rule, read only

   localparam reg_addr_t addr_rule_enable  = 8'h88;
   localparam reg_addr_t addr_trig_enable  = 8'h89;
   localparam reg_addr_t addr_trig_delay   = 8'h8A;
   localparam reg_addr_t addr_trig_width   = 8'h8B;

   // bit 0 arms (1) or disarms (0), bit 1 clears the hit counters
   localparam reg_addr_t addr_control      = 8'h8C;

   // bit 0 armed, bit 1 busy
   localparam reg_addr_t addr_status       = 8'h8D;

   localparam int ctrl_arm_bit   = 0;
   localparam int ctrl_clear_bit = 1;

endpackage

`default_nettype wire

// File: verilog/trace_regs.sv
// Register file for the trace trigger; holds rule and trigger settings and serves bus reads
`timescale 1ns/1ps
`default_nettype none

module trace_regs #(
   parameter int num_rules   = 8,
   parameter int window_bits = 64
) (
   input  logic                                  trace_clk,
   input  logic                                  reset,
   input  trace_pkg::reg_addr_t                  reg_addr,
   input  trace_pkg::reg_data_t                  reg_wdata,
   input  logic                                  reg_write,
   input  logic                                  reg_read,
   output trace_pkg::reg_data_t                  reg_rdata,
   input  trace_pkg::count_t [num_rules-1:0]     counts,
   input  logic                                  armed,
   input  logic                                  busy,
   output logic [num_rules-1:0][window_bits-1:0] rule_patterns,
   output logic [num_rules-1:0][window_bits-1:0] rule_masks,
   output logic [num_rules-1:0]                  rule_enable,
   output logic [num_rules-1:0]                  trig_enable,
   output trace_pkg::trig_cfg_t                  trig_cfg,
   output logic                                  arm_set,
   output logic                                  arm_clear,
   output logic                                  clear_counts
);
   import trace_pkg::*;

   localparam int window_bytes = window_bits / 8;

   logic      ctrl_write;
   reg_data_t rd_next;

   // control writes become single-cycle pulses, acting at the writing edge
   assign ctrl_write   = reg_write && (reg_addr == addr_control);
   assign arm_set      = ctrl_write && reg_wdata[ctrl_arm_bit];
   assign arm_clear    = ctrl_write && !reg_wdata[ctrl_arm_bit];
   assign clear_counts = ctrl_write && reg_wdata[ctrl_clear_bit];

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         rule_patterns <= '0;
         rule_masks    <= '0;
         rule_enable   <= '0;
         trig_enable   <= '0;
         trig_cfg      <= '0;
      end else if (reg_write) begin
         for (int r = 0; r < num_rules; r++) begin
            for (int b = 0; b < window_bytes; b++) begin
               if (reg_addr == reg_addr_t'(addr_pattern_base + r * 8 + b)) begin
                  rule_patterns[r][b*8 +: 8] <= reg_wdata;
               end
               if (reg_addr == reg_addr_t'(addr_mask_base + r * 8 + b)) begin
                  rule_masks[r][b*8 +: 8] <= reg_wdata;
               end
            end
         end
         case (reg_addr)
            addr_rule_enable: rule_enable    <= reg_wdata[num_rules-1:0];
            addr_trig_enable: trig_enable    <= reg_wdata[num_rules-1:0];
            addr_trig_delay:  trig_cfg.delay <= reg_wdata;
            addr_trig_width:  trig_cfg.width <= reg_wdata;
            default: ;                        // unmapped or read-only
         endcase
      end
   end

   // read mux, bytes beyond the configured rules and window stay 0
   always_comb begin
      rd_next = '0;
      for (int r = 0; r < num_rules; r++) begin
         for (int b = 0; b < window_bytes; b++) begin
            if (reg_addr == reg_addr_t'(addr_pattern_base + r * 8 + b)) begin
               rd_next = rule_patterns[r][b*8 +: 8];
            end
            if (reg_addr == reg_addr_t'(addr_mask_base + r * 8 + b)) begin
               rd_next = rule_masks[r][b*8 +: 8];
            end
         end
         if (reg_addr == reg_addr_t'(addr_count_base + r)) begin
            rd_next = counts[r];
         end
      end
      case (reg_addr)
         addr_rule_enable: rd_next = reg_data_t'(rule_enable);
         addr_trig_enable: rd_next = reg_data_t'(trig_enable);
         addr_trig_delay:  rd_next = trig_cfg.delay;
         addr_trig_width:  rd_next = trig_cfg.width;
         addr_status:      rd_next = reg_data_t'({busy, armed});
         default: ;                           // control is write only
      endcase
   end

   // read data held until the next read strobe
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         reg_rdata <= '0;
      end else if (reg_read) begin
         reg_rdata <= rd_next;
      end
   end

endmodule

`default_nettype wire

// File: verilog/pattern_matcher.sv
// Trace window shift register with a masked compare per rule; feeds counters and trigger
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher #(
   parameter int num_rules   = 8,
   parameter int window_bits = 64
) (
   input  logic                                  trace_clk,
   input  logic                                  reset,
   input  logic [trace_pkg::lane_bits-1:0]       trace_data,
   input  logic [num_rules-1:0][window_bits-1:0] rule_patterns,
   input  logic [num_rules-1:0][window_bits-1:0] rule_masks,
   input  logic [num_rules-1:0]                  rule_enable,
   output logic [num_rules-1:0]                  match_hits
);
   import trace_pkg::*;

   logic [window_bits-1:0] window;
   logic [num_rules-1:0]   rule_equal;

   // newest nibble enters at the bottom, older ones move up
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         window <= '0;
      end else begin
         window <= {window[window_bits-lane_bits-1:0], trace_data};
      end
   end

   // a mask bit of 1 means the window bit must equal the pattern bit
   always_comb begin
      for (int r = 0; r < num_rules; r++) begin
         rule_equal[r] = ((window & rule_masks[r]) == (rule_patterns[r] & rule_masks[r]));
      end
   end

   // hits lag the window by one edge
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         match_hits <= '0;
      end else begin
         match_hits <= rule_equal & rule_enable;
      end
   end

endmodule

`default_nettype wire

// File: verilog/match_counters.sv
// Per-rule saturating hit counters, cleared from the control register
`timescale 1ns/1ps
`default_nettype none

module match_counters #(
   parameter int num_rules = 8
) (
   input  logic                              trace_clk,
   input  logic                              reset,
   input  logic [num_rules-1:0]              match_hits,
   input  logic                              clear_counts,
   output trace_pkg::count_t [num_rules-1:0] counts
);
   import trace_pkg::*;

   localparam count_t count_max = '1;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         counts <= '0;
      end else if (clear_counts) begin
         counts <= '0;                        // clear beats a hit on the same edge
      end else begin
         for (int r = 0; r < num_rules; r++) begin
            if (match_hits[r] && (counts[r] != count_max)) begin
               counts[r] <= counts[r] + 1'b1;  // stops at 255
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/trigger_pulse.sv
// One-shot trigger sequencer; arms from the registers, waits the delay, then drives the pulse
`timescale 1ns/1ps
`default_nettype none

module trigger_pulse (
   input  logic                 trace_clk,
   input  logic                 reset,
   input  logic                 fire,
   input  trace_pkg::trig_cfg_t trig_cfg,
   input  logic                 arm_set,
   input  logic                 arm_clear,
   output logic                 armed,
   output logic                 busy,
   output logic                 trig_out
);

   typedef enum logic [1:0] {
      st_idle,
      st_delay,
      st_pulse
   } state_t;

   state_t     state;
   logic [7:0] cnt;                           // delay or width countdown
   logic [7:0] width_m1;

   // a width of 0 still gives one cycle
   assign width_m1 = (trig_cfg.width == 8'd0) ? 8'd0 : trig_cfg.width - 8'd1;

   assign busy     = (state != st_idle);
   assign trig_out = (state == st_pulse);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state <= st_idle;
         armed <= 1'b0;
         cnt   <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (armed && fire) begin
                  armed <= 1'b0;              // single pulse per arm
                  if (trig_cfg.delay == 8'd0) begin
                     state <= st_pulse;
                     cnt   <= width_m1;
                  end else begin
                     state <= st_delay;
                     cnt   <= trig_cfg.delay - 8'd1;
                  end
               end else if (arm_set) begin
                  armed <= 1'b1;
               end else if (arm_clear) begin
                  armed <= 1'b0;
               end
            end
            st_delay: begin
               if (cnt == 8'd0) begin
                  state <= st_pulse;
                  cnt   <= width_m1;
               end else begin
                  cnt <= cnt - 8'd1;
               end
            end
            default: begin                    // st_pulse
               if (cnt == 8'd0) begin
                  state <= st_idle;
               end else begin
                  cnt <= cnt - 8'd1;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/trace_top.sv
// Top level of the trace pattern trigger; connects registers, matcher, counters and trigger
`timescale 1ns/1ps
`default_nettype none

module trace_top #(
   parameter int num_rules   = 8,
   parameter int window_bits = 64
) (
   input  logic                            trace_clk,
   input  logic                            reset,
   input  logic [trace_pkg::lane_bits-1:0] trace_data,
   input  trace_pkg::reg_addr_t            reg_addr,
   input  trace_pkg::reg_data_t            reg_wdata,
   input  logic                            reg_write,
   input  logic                            reg_read,
   output trace_pkg::reg_data_t            reg_rdata,
   output logic                            trig_out,
   output logic                            armed
);
   import trace_pkg::*;

   logic [num_rules-1:0][window_bits-1:0] rule_patterns;
   logic [num_rules-1:0][window_bits-1:0] rule_masks;
   logic [num_rules-1:0]                  rule_enable;
   logic [num_rules-1:0]                  trig_enable;
   logic [num_rules-1:0]                  match_hits;
   count_t [num_rules-1:0]                counts;
   trig_cfg_t                             trig_cfg;
   logic                                  arm_set;
   logic                                  arm_clear;
   logic                                  clear_counts;
   logic                                  busy;

   trace_regs #(
      .num_rules     (num_rules),
      .window_bits   (window_bits)
   ) u_regs (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .reg_write     (reg_write),
      .reg_read      (reg_read),
      .reg_rdata     (reg_rdata),
      .counts        (counts),
      .armed         (armed),
      .busy          (busy),
      .rule_patterns (rule_patterns),
      .rule_masks    (rule_masks),
      .rule_enable   (rule_enable),
      .trig_enable   (trig_enable),
      .trig_cfg      (trig_cfg),
      .arm_set       (arm_set),
      .arm_clear     (arm_clear),
      .clear_counts  (clear_counts)
   );

   pattern_matcher #(
      .num_rules     (num_rules),
      .window_bits   (window_bits)
   ) u_matcher (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .trace_data    (trace_data),
      .rule_patterns (rule_patterns),
      .rule_masks    (rule_masks),
      .rule_enable   (rule_enable),
      .match_hits    (match_hits)
   );

   match_counters #(
      .num_rules     (num_rules)
   ) u_counters (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .match_hits    (match_hits),
      .clear_counts  (clear_counts),
      .counts        (counts)
   );

   trigger_pulse u_trigger (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .fire          (|(match_hits & trig_enable)),  // only trigger-enabled rules fire
      .trig_cfg      (trig_cfg),
      .arm_set       (arm_set),
      .arm_clear     (arm_clear),
      .armed         (armed),
      .busy          (busy),
      .trig_out      (trig_out)
   );

endmodule

`default_nettype wire

// File: tests/tb_trace_top.sv
// Self-checking testbench for trace_top; drives the register bus and trace lanes, run via list.f
`timescale 1ns/1ps
`default_nettype none

module tb_trace_top;
   import trace_pkg::*;

   localparam int num_rules    = 8;
   localparam int window_bits  = 64;
   localparam int clk_period   = 40;
   localparam int rand_cycles  = 300;
   localparam int total_cycles = 3 * 256 + rand_cycles + 400;  // register sweeps dominate
   localparam int timeout_ns   = total_cycles * clk_period * 2;
   localparam logic [15:0] trig_word = 16'hC3A5;              // last nibble completes it

   logic                   trace_clk;
   logic                   reset;
   logic [lane_bits-1:0]   trace_data;
   reg_addr_t              reg_addr;
   reg_data_t              reg_wdata;
   logic                   reg_write;
   logic                   reg_read;
   reg_data_t              reg_rdata;
   logic                   trig_out;
   logic                   armed;

   logic [window_bits-1:0] model_window;   // mirror of the DUT trace window
   logic [31:0]            rand_state;
   reg_data_t              shadow [0:255];  // expected read value per address

   trace_top #(
      .num_rules   (num_rules),
      .window_bits (window_bits)
   ) dut0 (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_write   (reg_write),
      .reg_read    (reg_read),
      .reg_rdata   (reg_rdata),
      .trig_out    (trig_out),
      .armed       (armed)
   );

   initial trace_clk = 1'b0;
   always #(clk_period / 2) trace_clk = ~trace_clk;

   // newest nibble at the bottom, as seen after each edge
   always @(posedge trace_clk) begin
      if (reset) begin
         model_window <= '0;
      end else begin
         model_window <= {model_window[window_bits-lane_bits-1:0], trace_data};
      end
   end

   initial begin
      #(timeout_ns);
      $display("timeout: the run did not finish within %0d ns", timeout_ns);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic window_matches(input logic [63:0] window,
                                           input logic [63:0] pattern,
                                           input logic [63:0] mask);
      return (window & mask) == (pattern & mask);
   endfunction

   function automatic count_t saturate(input int hits);
      return (hits > 255) ? 8'd255 : count_t'(hits);
   endfunction

   // patterns and masks of 8 rules x 64 bits fill everything below the counts
   function automatic logic is_writable(input int a);
      return (a < int'(addr_count_base)) ||
             (a >= int'(addr_rule_enable) && a <= int'(addr_trig_width));
   endfunction

   task automatic check_byte(input string what, input reg_data_t got, input reg_data_t expected);
      assert (got === expected) else begin
         $display("MISMATCH at %0t ns: %s is %02h, expected %02h", $time, what, got, expected);
         $display("*** FAILED ***");
         $fatal(1, "byte check failed");
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic expected);
      assert (got === expected) else begin
         $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, expected);
         $display("*** FAILED ***");
         $fatal(1, "bit check failed");
      end
   endtask

   task automatic next_random(output reg_data_t value);
      rand_state = lcg_step(rand_state);
      value      = rand_state[23:16];
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge trace_clk);
         #1;
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      reg_addr  = addr;
      reg_wdata = data;
      reg_write = 1'b1;
      @(posedge trace_clk);
      #1;
      reg_write = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
      reg_addr = addr;
      reg_read = 1'b1;
      @(posedge trace_clk);
      #1;
      reg_read = 1'b0;
      data     = reg_rdata;                 // held until the next read
   endtask

   task automatic set_rule(input int r, input logic [63:0] pattern, input logic [63:0] mask);
      for (int b = 0; b < window_bits / 8; b++) begin
         write_reg(reg_addr_t'(int'(addr_pattern_base) + r * 8 + b), pattern[b*8 +: 8]);
         write_reg(reg_addr_t'(int'(addr_mask_base) + r * 8 + b), mask[b*8 +: 8]);
      end
   endtask

   // arm, send the trigger word, then keep repeating it while busy and after
   task automatic pulse_check(input reg_data_t delay, input reg_data_t width);
      int pulse_len;
      int delay_i;
      int last_edge;
      pulse_len = (width == 8'd0) ? 1 : int'(width);
      delay_i   = int'(delay);
      last_edge = delay_i + 2 + pulse_len + 6;
      write_reg(addr_trig_delay, delay);
      write_reg(addr_trig_width, width);
      write_reg(addr_control, 8'h01);
      check_bit("armed after arm write", armed, 1'b1);
      for (int i = 0; i < 4; i++) begin
         trace_data = trig_word[(3 - i) * 4 +: 4];
         idle(1);
      end
      for (int e = 1; e <= last_edge; e++) begin
         trace_data = trig_word[(3 - ((e - 1) % 4)) * 4 +: 4];
         reg_write  = (e == 3);             // arm attempt while busy
         reg_read   = (e == 4);             // status sampled mid-sequence
         reg_addr   = (e == 4) ? addr_status : addr_control;
         reg_wdata  = 8'h01;
         idle(1);
         check_bit($sformatf("trig_out %0d edges after match", e), trig_out,
                   (e >= delay_i + 2) && (e < delay_i + 2 + pulse_len));
         check_bit($sformatf("armed %0d edges after match", e), armed, (e < 2));
         if (e == 4) begin
            // busy from the edge after the fire hit until the pulse ends
            check_byte("status during the trigger sequence", reg_rdata,
                       {6'd0, (delay_i + 2 + pulse_len >= 4), 1'b0});
         end
      end
      reg_write  = 1'b0;
      reg_read   = 1'b0;
      trace_data = '0;
      idle(4);
   endtask

   initial begin
      reg_data_t rd;
      reg_data_t rnd;
      int        hits0;
      int        hits1;
      reset      = 1'b1;
      trace_data = '0;
      reg_addr   = '0;
      reg_wdata  = '0;
      reg_write  = 1'b0;
      reg_read   = 1'b0;
      rand_state = 32'hb81a9b9b;
      repeat (3) @(posedge trace_clk);
      #1;
      reset = 1'b0;

      // everything reads 0 after reset
      check_bit("trig_out after reset", trig_out, 1'b0);
      check_bit("armed after reset", armed, 1'b0);
      for (int a = 0; a < 256; a++) begin
         read_reg(reg_addr_t'(a), rd);
         check_byte($sformatf("reset value of %02h", a), rd, 8'h00);
      end

      // random write sweep, control skipped since it would arm
      for (int a = 0; a < 256; a++) begin
         shadow[a] = 8'h00;
      end
      for (int a = 0; a < 256; a++) begin
         if (reg_addr_t'(a) != addr_control) begin
            next_random(rnd);
            write_reg(reg_addr_t'(a), rnd);
            if (is_writable(a)) begin
               shadow[a] = rnd;
            end
         end
      end
      for (int a = 0; a < 256; a++) begin
         if (a < int'(addr_count_base) || a >= int'(addr_count_base) + num_rules) begin
            read_reg(reg_addr_t'(a), rd);
            check_byte($sformatf("readback of %02h", a), rd, shadow[a]);
         end
      end

      // hit counting against the window model
      write_reg(addr_rule_enable, 8'h00);
      write_reg(addr_trig_enable, 8'h00);
      set_rule(0, 64'h0, 64'h0);           // every window matches
      set_rule(1, 64'hA0, 64'hF0);         // previous nibble must be A
      write_reg(addr_control, 8'h02);
      write_reg(addr_rule_enable, 8'h03);
      hits0 = 0;
      hits1 = 0;
      for (int i = 0; i <= rand_cycles; i++) begin
         if (window_matches(model_window, 64'h0, 64'h0)) begin
            hits0++;
         end
         if (window_matches(model_window, 64'hA0, 64'hF0)) begin
            hits1++;
         end
         if (i < rand_cycles) begin
            next_random(rnd);
            trace_data = rnd[3:0];
            idle(1);
         end
      end
      trace_data = '0;
      write_reg(addr_rule_enable, 8'h00);
      idle(2);                              // let the last hits reach the counters
      for (int r = 0; r < num_rules; r++) begin
         read_reg(reg_addr_t'(int'(addr_count_base) + r), rd);
         check_byte($sformatf("count of rule %0d", r), rd,
                    (r == 0) ? saturate(hits0) : ((r == 1) ? saturate(hits1) : 8'h00));
      end
      write_reg(addr_control, 8'h02);
      for (int r = 0; r < num_rules; r++) begin
         read_reg(reg_addr_t'(int'(addr_count_base) + r), rd);
         check_byte($sformatf("cleared count of rule %0d", r), rd, 8'h00);
      end

      // trigger timing, rule 3 counts but may not fire
      set_rule(2, 64'(trig_word), 64'hFFFF);
      set_rule(3, 64'h7E, 64'hFF);
      write_reg(addr_rule_enable, 8'h0C);
      write_reg(addr_trig_enable, 8'h04);
      pulse_check(8'd5, 8'd3);
      pulse_check(8'd0, 8'd0);
      pulse_check(8'd1, 8'd2);

      write_reg(addr_control, 8'h02);       // clear also disarms
      write_reg(addr_control, 8'h01);
      read_reg(addr_status, rd);
      check_byte("status while armed", rd, 8'h01);
      for (int i = 0; i < 12; i++) begin
         trace_data = (i % 3 == 0) ? 4'h7 : ((i % 3 == 1) ? 4'hE : 4'h0);
         idle(1);
         check_bit("trig_out from a rule without trig_enable", trig_out, 1'b0);
         check_bit("armed with only non-firing hits", armed, 1'b1);
      end
      trace_data = '0;
      idle(2);
      read_reg(reg_addr_t'(int'(addr_count_base) + 3), rd);
      check_byte("count of non-firing rule", rd, 8'd4);   // four 7E windows sent
      read_reg(reg_addr_t'(int'(addr_count_base) + 2), rd);
      check_byte("count of trigger rule", rd, 8'h00);
      write_reg(addr_control, 8'h00);
      check_bit("armed after disarm", armed, 1'b0);
      read_reg(addr_status, rd);
      check_byte("status after disarm", rd, 8'h00);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
verilog/trace_pkg.sv
verilog/trace_regs.sv
verilog/pattern_matcher.sv
verilog/match_counters.sv
verilog/trigger_pulse.sv
verilog/trace_top.sv
tests/tb_trace_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the trace trigger testbench with Verilator and run it.
# The exit status is nonzero if the build fails or the simulation fails.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --timescale 1ns/1ps \
   --top-module tb_trace_top \
   -f list.f \
   -o tb_trace_top_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/tb_trace_top_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

exit 0
